// ==== design/sd_pkg.sv ====
// Shared types and register map; channel words hold 16-bit signed fields, sign-extended on APB reads
package sd_pkg;

    ////////////////////
    // APB bus
    ////////////////////

    // Request from the APB master, 12-bit byte address
    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [11:0] paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    // Response back to the master
    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    ////////////////////
    // Channel data
    ////////////////////

    // Per-channel correction and fault limits
    typedef struct packed {
        logic signed [15:0] offset;
        logic signed [15:0] thresh_high;
        logic signed [15:0] thresh_low;
    } sd_chan_cfg_t;

    // One streamed word, value is CIC output minus offset
    typedef struct packed {
        logic [1:0]         chan;
        logic               fault_high;
        logic               fault_low;
        logic signed [15:0] value;
    } sd_sample_t;

    ////////////////////
    // Register map
    ////////////////////

    localparam logic [11:0] REG_CTRL        = 12'h000;
    localparam logic [11:0] REG_STATUS      = 12'h004;
    // Channel n block starts at REG_CHAN_BASE + n * 0x10
    localparam logic [11:0] REG_CHAN_BASE   = 12'h010;
    // Field offsets inside a channel block
    localparam logic [3:0]  REG_OFFSET      = 4'h0;
    localparam logic [3:0]  REG_THRESH_HIGH = 4'h4;
    localparam logic [3:0]  REG_THRESH_LOW  = 4'h8;

    // Limits wide open after reset so no fault fires
    localparam sd_chan_cfg_t CHAN_CFG_RESET = '{
        offset:      16'sh0000,
        thresh_high: 16'sh7fff,
        thresh_low:  16'sh8000
    };

    // Accumulator width of a third-order CIC
    function automatic int cic_width(input int decimation);
        return 3 * $clog2(decimation) + 1;
    endfunction

    // Counter width for a modulus, never below one bit
    function automatic int ctr_width(input int modulus);
        return (modulus > 1) ? $clog2(modulus) : 1;
    endfunction

endpackage

// ==== design/sd_clock_gen.sv ====
// CLK_DIV must be even and at least 4; all outputs and counters sit at zero while enable is low
`timescale 1ns/1ns

module sd_clock_gen #(
    parameter int CLK_DIV    = 4,
    parameter int DECIMATION = 16
) (
    input  logic clock,
    input  logic rst_n,
    input  logic enable,
    output logic sd_clk,
    output logic bit_strobe,
    output logic frame_strobe
);
    import sd_pkg::*;

    // System clocks per half period of the modulator clock
    localparam int HALF   = CLK_DIV / 2;
    localparam int HALF_W = ctr_width(HALF);
    localparam int BIT_W  = ctr_width(DECIMATION);

    logic [HALF_W-1:0] half_cnt;
    logic [BIT_W-1:0]  bit_cnt;
    logic              half_end;
    logic              rise;
    logic              frame_end;

    // Last cycle of a half period, sd_clk toggles on this edge
    assign half_end  = (half_cnt == HALF_W'(HALF - 1));
    // Toggle from low means the next cycle shows a rising sd_clk
    assign rise      = half_end && !sd_clk;
    // This rising edge closes the frame
    assign frame_end = (bit_cnt == BIT_W'(DECIMATION - 1));

    ////////////////////
    // Divider and bit counter
    ////////////////////

    always_ff @(posedge clock) begin
        if (!rst_n || !enable) begin
            half_cnt     <= '0;
            bit_cnt      <= '0;
            sd_clk       <= 1'b0;
            bit_strobe   <= 1'b0;
            frame_strobe <= 1'b0;
        end else begin
            half_cnt <= half_end ? '0 : half_cnt + 1'b1;
            if (half_end) begin
                sd_clk <= ~sd_clk;
            end
            // Registered together with sd_clk so both line up
            bit_strobe   <= rise;
            frame_strobe <= rise && frame_end;
            if (rise) begin
                bit_cnt <= frame_end ? '0 : bit_cnt + 1'b1;
            end
        end
    end

endmodule

// ==== design/sd_cic_channel.sv ====
// DECIMATION must be a power of two from 4 to 32; values beyond 16-bit signed range saturate
`timescale 1ns/1ns

module sd_cic_channel #(
    parameter int DECIMATION = 16,
    parameter int CHANNEL    = 0
) (
    input  logic                 clock,
    input  logic                 rst_n,
    input  logic                 bit_strobe,
    input  logic                 frame_strobe,
    input  logic                 sd_bit,
    input  sd_pkg::sd_chan_cfg_t cfg,
    output sd_pkg::sd_sample_t   result
);
    import sd_pkg::*;

    localparam int CW = cic_width(DECIMATION);
    // Room for the unsigned CIC output minus a signed offset
    localparam int DW = 18;

    // Integrator chain, wraps modulo 2**CW
    logic [CW-1:0] integ1;
    logic [CW-1:0] integ2;
    logic [CW-1:0] integ3;
    // Comb delay registers, one frame back
    logic [CW-1:0] dly1;
    logic [CW-1:0] dly2;
    logic [CW-1:0] dly3;
    logic [CW-1:0] comb1;
    logic [CW-1:0] comb2;
    logic [CW-1:0] comb3;

    logic signed [DW-1:0] cic_ext;
    logic signed [DW-1:0] offset_ext;
    logic signed [DW-1:0] high_ext;
    logic signed [DW-1:0] low_ext;
    logic signed [DW-1:0] corrected;
    logic signed [15:0]   value_sat;

    ////////////////////
    // Integrators
    ////////////////////

    // Modulator bit taken as 1 or 0
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            integ1 <= '0;
            integ2 <= '0;
            integ3 <= '0;
        end else if (bit_strobe) begin
            integ1 <= integ1 + {{(CW - 1){1'b0}}, sd_bit};
            integ2 <= integ2 + integ1;
            integ3 <= integ3 + integ2;
        end
    end

    ////////////////////
    // Combs at frame rate
    ////////////////////

    // Differences are exact mod 2**CW since the output stays below 2**CW
    assign comb1 = integ3 - dly1;
    assign comb2 = comb1 - dly2;
    assign comb3 = comb2 - dly3;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            dly1 <= '0;
            dly2 <= '0;
            dly3 <= '0;
        end else if (frame_strobe) begin
            dly1 <= integ3;
            dly2 <= comb1;
            dly3 <= comb2;
        end
    end

    ////////////////////
    // Offset and thresholds
    ////////////////////

    // CIC output is a count, so zero-extend it
    assign cic_ext    = signed'({{(DW - CW){1'b0}}, comb3});
    assign offset_ext = signed'({{(DW - 16){cfg.offset[15]}}, cfg.offset});
    assign high_ext   = signed'({{(DW - 16){cfg.thresh_high[15]}}, cfg.thresh_high});
    assign low_ext    = signed'({{(DW - 16){cfg.thresh_low[15]}}, cfg.thresh_low});
    assign corrected  = cic_ext - offset_ext;

    // Clamp into the 16-bit word
    always_comb begin
        if (corrected > signed'(DW'(32767))) begin
            value_sat = 16'sh7fff;
        end else if (corrected < -signed'(DW'(32768))) begin
            value_sat = 16'sh8000;
        end else begin
            value_sat = corrected[15:0];
        end
    end

    // Result word, compares use the unclamped difference
    always_ff @(posedge clock) begin
        if (frame_strobe) begin
            result.chan       <= 2'(CHANNEL);
            result.fault_high <= (corrected > high_ext);
            result.fault_low  <= (corrected < low_ext);
            result.value      <= value_sat;
        end
    end

endmodule

// ==== design/sd_regs_apb.sv ====
// No wait states; 16-bit channel fields read back sign-extended, unmapped reads give 0 and pslverr
`timescale 1ns/1ns

module sd_regs_apb #(
    parameter int N_CHANNELS = 2
) (
    input  logic                 clock,
    input  logic                 rst_n,
    input  sd_pkg::apb_req_t     apb_req,
    output sd_pkg::apb_rsp_t     apb_rsp,
    output logic                 enable,
    output sd_pkg::sd_chan_cfg_t cfg [N_CHANNELS],
    input  logic                 overrun,
    input  sd_pkg::sd_sample_t   samples [N_CHANNELS],
    input  logic                 frame_done
);
    import sd_pkg::*;

    localparam int IDX_W = ctr_width(N_CHANNELS);

    logic                  access;
    logic                  wr_en;
    logic                  ctrl_hit;
    logic                  status_hit;
    logic                  chan_hit;
    logic [11:0]           chan_rel;
    logic [7:0]            chan_blk;
    logic [3:0]            chan_field;
    logic [IDX_W-1:0]      chan_sel;
    logic [31:0]           rdata;
    logic                  overrun_sticky;
    logic [N_CHANNELS-1:0] fault_sticky;
    logic [N_CHANNELS-1:0] fault_set;
    logic [N_CHANNELS-1:0] fault_clr;

    function automatic logic [31:0] sext16(input logic [15:0] v);
        return {{16{v[15]}}, v};
    endfunction

    ////////////////////
    // Address decode
    ////////////////////

    // Access phase of an APB transfer
    assign access     = apb_req.psel && apb_req.penable;
    assign wr_en      = access && apb_req.pwrite;
    assign ctrl_hit   = (apb_req.paddr == REG_CTRL);
    assign status_hit = (apb_req.paddr == REG_STATUS);

    // Offset into the channel blocks, 16 bytes each
    assign chan_rel   = apb_req.paddr - REG_CHAN_BASE;
    assign chan_blk   = chan_rel[11:4];
    assign chan_field = chan_rel[3:0];
    assign chan_sel   = chan_blk[IDX_W-1:0];
    assign chan_hit   = (apb_req.paddr >= REG_CHAN_BASE)
                     && (chan_blk < 8'(N_CHANNELS))
                     && (chan_field == REG_OFFSET
                      || chan_field == REG_THRESH_HIGH
                      || chan_field == REG_THRESH_LOW);

    always_comb begin
        rdata = '0;
        if (ctrl_hit) begin
            rdata[0] = enable;
        end else if (status_hit) begin
            rdata[0]              = overrun_sticky;
            rdata[8 +: N_CHANNELS] = fault_sticky;
        end else if (chan_hit) begin
            case (chan_field)
                REG_OFFSET:      rdata = sext16(cfg[chan_sel].offset);
                REG_THRESH_HIGH: rdata = sext16(cfg[chan_sel].thresh_high);
                default:         rdata = sext16(cfg[chan_sel].thresh_low);
            endcase
        end
    end

    assign apb_rsp.prdata  = rdata;
    assign apb_rsp.pready  = 1'b1;
    assign apb_rsp.pslverr = access && !(ctrl_hit || status_hit || chan_hit);

    ////////////////////
    // Sticky status
    ////////////////////

    // Either fault of a channel sets its bit once the frame is taken
    always_comb begin
        for (int ch = 0; ch < N_CHANNELS; ch++) begin
            fault_set[ch] = frame_done && (samples[ch].fault_high || samples[ch].fault_low);
        end
    end

    // Write 1 to clear, a new event in the same cycle wins
    assign fault_clr = (wr_en && status_hit) ? apb_req.pwdata[8 +: N_CHANNELS] : '0;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            enable         <= 1'b0;
            overrun_sticky <= 1'b0;
            fault_sticky   <= '0;
            for (int ch = 0; ch < N_CHANNELS; ch++) begin
                cfg[ch] <= CHAN_CFG_RESET;
            end
        end else begin
            overrun_sticky <= overrun
                           || (overrun_sticky && !(wr_en && status_hit && apb_req.pwdata[0]));
            fault_sticky   <= fault_set | (fault_sticky & ~fault_clr);
            if (wr_en && ctrl_hit) begin
                enable <= apb_req.pwdata[0];
            end
            if (wr_en && chan_hit) begin
                case (chan_field)
                    REG_OFFSET:      cfg[chan_sel].offset      <= apb_req.pwdata[15:0];
                    REG_THRESH_HIGH: cfg[chan_sel].thresh_high <= apb_req.pwdata[15:0];
                    default:         cfg[chan_sel].thresh_low  <= apb_req.pwdata[15:0];
                endcase
            end
        end
    end

endmodule

// ==== design/sd_output_sequencer.sv ====
// A frame that arrives before the previous one is fully sent is dropped; waits forever on ready
`timescale 1ns/1ns

module sd_output_sequencer #(
    parameter int N_CHANNELS = 2
) (
    input  logic               clock,
    input  logic               rst_n,
    input  logic               frame_strobe,
    input  logic               sample_ready,
    input  sd_pkg::sd_sample_t samples [N_CHANNELS],
    output sd_pkg::sd_sample_t sample,
    output logic               sample_valid,
    output logic               overrun,
    output logic               frame_done
);
    import sd_pkg::*;

    localparam int IDX_W = ctr_width(N_CHANNELS);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT,
        ST_SEND
    } state_t;

    state_t           state;
    logic [IDX_W-1:0] idx;
    logic             xfer;
    logic             last;
    sd_sample_t       frame_buf [N_CHANNELS];

    assign xfer = sample_valid && sample_ready;
    // Channel being presented is the final one of the frame
    assign last = (idx == IDX_W'(N_CHANNELS - 1));

    // Outputs straight from state and buffer, stable until the transfer
    assign sample_valid = (state == ST_SEND);
    assign frame_done   = (state == ST_WAIT);
    assign sample       = frame_buf[idx];

    ////////////////////
    // Sequencer FSM
    ////////////////////

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state   <= ST_IDLE;
            idx     <= '0;
            overrun <= 1'b0;
        end else begin
            overrun <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (frame_strobe) begin
                        state <= ST_WAIT;
                    end
                end
                // Channels register their result in this cycle
                ST_WAIT: begin
                    state <= ST_SEND;
                    idx   <= '0;
                end
                ST_SEND: begin
                    if (xfer && last) begin
                        // Frame fully sent, a strobe now is taken normally
                        state <= frame_strobe ? ST_WAIT : ST_IDLE;
                        idx   <= '0;
                    end else begin
                        if (xfer) begin
                            idx <= idx + 1'b1;
                        end
                        // Words still pending, drop the new frame
                        if (frame_strobe) begin
                            overrun <= 1'b1;
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Snapshot of all channels at the end of WAIT
    always_ff @(posedge clock) begin
        if (state == ST_WAIT) begin
            frame_buf <= samples;
        end
    end

endmodule

// ==== design/sd_processor.sv ====
// N_CHANNELS 1 to 4, CLK_DIV even and at least 4, DECIMATION a power of two from 4 to 32
`timescale 1ns/1ns

module sd_processor #(
    parameter int N_CHANNELS = 2,
    parameter int CLK_DIV    = 4,
    parameter int DECIMATION = 16
) (
    input  logic                  clock,
    input  logic                  rst_n,
    input  logic [N_CHANNELS-1:0] sd_data,
    output logic                  sd_clk,
    input  sd_pkg::apb_req_t      apb_req,
    output sd_pkg::apb_rsp_t      apb_rsp,
    output sd_pkg::sd_sample_t    sample,
    output logic                  sample_valid,
    input  logic                  sample_ready
);
    import sd_pkg::*;

    logic         enable;
    logic         bit_strobe;
    logic         frame_strobe;
    logic         overrun;
    logic         frame_done;
    sd_chan_cfg_t chan_cfg [N_CHANNELS];
    sd_sample_t   chan_result [N_CHANNELS];

    ////////////////////
    // Modulator clock
    ////////////////////

    sd_clock_gen #(
        .CLK_DIV    (CLK_DIV),
        .DECIMATION (DECIMATION)
    ) i_clock_gen (
        .clock        (clock),
        .rst_n        (rst_n),
        .enable       (enable),
        .sd_clk       (sd_clk),
        .bit_strobe   (bit_strobe),
        .frame_strobe (frame_strobe)
    );

    ////////////////////
    // Filter channels
    ////////////////////

    for (genvar ch = 0; ch < N_CHANNELS; ch++) begin : g_chan
        sd_cic_channel #(
            .DECIMATION (DECIMATION),
            .CHANNEL    (ch)
        ) i_channel (
            .clock        (clock),
            .rst_n        (rst_n),
            .bit_strobe   (bit_strobe),
            .frame_strobe (frame_strobe),
            .sd_bit       (sd_data[ch]),
            .cfg          (chan_cfg[ch]),
            .result       (chan_result[ch])
        );
    end

    ////////////////////
    // Registers and output
    ////////////////////

    sd_regs_apb #(
        .N_CHANNELS (N_CHANNELS)
    ) i_regs (
        .clock      (clock),
        .rst_n      (rst_n),
        .apb_req    (apb_req),
        .apb_rsp    (apb_rsp),
        .enable     (enable),
        .cfg        (chan_cfg),
        .overrun    (overrun),
        .samples    (chan_result),
        .frame_done (frame_done)
    );

    sd_output_sequencer #(
        .N_CHANNELS (N_CHANNELS)
    ) i_sequencer (
        .clock        (clock),
        .rst_n        (rst_n),
        .frame_strobe (frame_strobe),
        .sample_ready (sample_ready),
        .samples      (chan_result),
        .sample       (sample),
        .sample_valid (sample_valid),
        .overrun      (overrun),
        .frame_done   (frame_done)
    );

endmodule

// ==== testbench/tb_clock.sv ====
// Free-running 8 ns clock; rst_n held low for the first 2 rising edges and released on a falling edge
`timescale 1ns/1ns

module tb_clock (
    output logic clock,
    output logic rst_n
);
    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    // Synchronous reset for two cycles
    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge clock);
        @(negedge clock);
        rst_n = 1'b1;
    end

endmodule

// ==== testbench/sd_props.sv ====
// Bound into sd_processor; channel order assumes every frame carries all N_CHANNELS words
`timescale 1ns/1ns

module sd_props #(
    parameter int N_CHANNELS = 2
) (
    input logic               clock,
    input logic               rst_n,
    input logic               enable,
    input logic               sd_clk,
    input logic               frame_strobe,
    input sd_pkg::sd_sample_t sample,
    input logic               sample_valid,
    input logic               sample_ready,
    input sd_pkg::apb_rsp_t   apb_rsp
);
    import sd_pkg::*;

    int         fail_count = 0;
    // Channel the next transfer must carry
    logic [1:0] next_chan;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            next_chan <= '0;
        end else if (sample_valid && sample_ready) begin
            next_chan <= (next_chan == 2'(N_CHANNELS - 1)) ? 2'd0 : next_chan + 2'd1;
        end
    end

    ////////////////////
    // Stream rules
    ////////////////////

    // Word and valid hold while the sink stalls
    a_stable: assert property (@(posedge clock) disable iff (!rst_n)
        sample_valid && !sample_ready |=> sample_valid && $stable(sample))
        else begin
            fail_count++;
            $error("stream word changed while stalled");
        end

    // Words of a frame leave in channel order
    a_order: assert property (@(posedge clock) disable iff (!rst_n)
        sample_valid && sample_ready |-> sample.chan == next_chan)
        else begin
            fail_count++;
            $error("channel out of order, expected %0d got %0d", next_chan, sample.chan);
        end

    ////////////////////
    // Enable and reset
    ////////////////////

    // Modulator clock parks low when disabled
    a_clk_off: assert property (@(posedge clock) disable iff (!rst_n)
        !enable |=> !sd_clk)
        else begin
            fail_count++;
            $error("sd_clk high while disabled");
        end

    // A word only appears two cycles after a strobe of an enabled frame
    a_valid_off: assert property (@(posedge clock) disable iff (!rst_n)
        $rose(sample_valid) |-> $past(frame_strobe, 2) && $past(enable, 3))
        else begin
            fail_count++;
            $error("sample_valid rose without a frame started while enabled");
        end

    a_reset: assert property (@(posedge clock)
        !rst_n |=> !sample_valid && !sd_clk)
        else begin
            fail_count++;
            $error("outputs not cleared by reset");
        end

    // Error responses carry no data
    a_slverr: assert property (@(posedge clock) disable iff (!rst_n)
        apb_rsp.pslverr |-> apb_rsp.prdata == 32'h0)
        else begin
            fail_count++;
            $error("pslverr with nonzero prdata");
        end

endmodule

bind sd_processor sd_props #(
    .N_CHANNELS (N_CHANNELS)
) i_props (
    .clock        (clock),
    .rst_n        (rst_n),
    .enable       (enable),
    .sd_clk       (sd_clk),
    .frame_strobe (frame_strobe),
    .sample       (sample),
    .sample_valid (sample_valid),
    .sample_ready (sample_ready),
    .apb_rsp      (apb_rsp)
);

// ==== testbench/tb_sd_processor.sv ====
// Two channels, CLK_DIV 4, DECIMATION 16; words in the settle window after any change go unchecked
`timescale 1ns/1ns

module tb_sd_processor;
    import sd_pkg::*;

    localparam int N_CH          = 2;
    localparam int CLK_DIV       = 4;
    localparam int DEC           = 16;
    // Frames skipped after a pattern or config change
    localparam int SETTLE_FRAMES = 5;
    localparam int TEST_FRAMES   = 80;
    localparam int TIMEOUT_NS    = TEST_FRAMES * DEC * CLK_DIV * 8 + 10000;

    logic            clock;
    logic            rst_n;
    logic [N_CH-1:0] sd_data = '0;
    logic            sd_clk;
    apb_req_t        apb_req;
    apb_rsp_t        apb_rsp;
    sd_sample_t      sample;
    logic            sample_valid;
    logic            sample_ready;

    // Rule model, one entry per channel
    int          raw_val [N_CH];
    int          offset_v [N_CH];
    int          thr_hi [N_CH];
    int          thr_lo [N_CH];
    int          mode [N_CH];
    int          frames_seen = 0;
    int          checked_frames = 0;
    int          settle_until = 0;
    int          tb_errors = 0;
    logic [31:0] lcg_state = 32'd69;
    logic        alt_phase = 1'b0;
    logic        sd_clk_prev = 1'b0;

    tb_clock i_clock (
        .clock (clock),
        .rst_n (rst_n)
    );

    sd_processor #(
        .N_CHANNELS (N_CH),
        .CLK_DIV    (CLK_DIV),
        .DECIMATION (DEC)
    ) i_dut (
        .clock        (clock),
        .rst_n        (rst_n),
        .sd_data      (sd_data),
        .sd_clk       (sd_clk),
        .apb_req      (apb_req),
        .apb_rsp      (apb_rsp),
        .sample       (sample),
        .sample_valid (sample_valid),
        .sample_ready (sample_ready)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    ////////////////////
    // APB tasks
    ////////////////////

    task automatic apb_write(input logic [11:0] addr, input logic [31:0] data);
        @(negedge clock);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = 1'b1;
        apb_req.paddr   = addr;
        apb_req.pwdata  = data;
        @(negedge clock);
        apb_req.penable = 1'b1;
        @(negedge clock);
        apb_req = '0;
    endtask

    // Response sampled in the access phase, one half cycle after the edge
    task automatic apb_read(input logic [11:0] addr, input logic [31:0] exp_data,
                            input logic exp_err);
        @(negedge clock);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = 1'b0;
        apb_req.paddr   = addr;
        @(negedge clock);
        apb_req.penable = 1'b1;
        @(negedge clock);
        if (apb_rsp.prdata !== exp_data || apb_rsp.pslverr !== exp_err
                || apb_rsp.pready !== 1'b1) begin
            tb_errors++;
            $display("ERR %0t: read 0x%03h got 0x%08h err %0b rdy %0b, exp 0x%08h err %0b",
                     $time, addr, apb_rsp.prdata, apb_rsp.pslverr, apb_rsp.pready,
                     exp_data, exp_err);
        end
        apb_req = '0;
    endtask

    task automatic set_chan_cfg(input int ch, input int off, input int hi, input int lo);
        logic [11:0] base;
        base = 12'h010 + 12'(ch * 16);
        apb_write(base, 32'(off));
        apb_write(base + 12'h4, 32'(hi));
        apb_write(base + 12'h8, 32'(lo));
        offset_v[ch] = off;
        thr_hi[ch]   = hi;
        thr_lo[ch]   = lo;
        settle_until = frames_seen + SETTLE_FRAMES;
    endtask

    // Pattern mode 0 zeros, 1 ones, 2 alternating
    task automatic set_pattern(input int ch, input int m, input int raw);
        mode[ch]     = m;
        raw_val[ch]  = raw;
        settle_until = frames_seen + SETTLE_FRAMES;
    endtask

    task automatic wait_frames(input int n);
        int target;
        target = checked_frames + n;
        wait (checked_frames >= target);
        @(negedge clock);
    endtask

    ////////////////////
    // Bitstreams
    ////////////////////

    // New bit after each rising sd_clk
    always @(negedge clock) begin
        if (sd_clk && !sd_clk_prev) begin
            alt_phase = ~alt_phase;
            for (int ch = 0; ch < N_CH; ch++) begin
                sd_data[ch] = (mode[ch] == 1) || (mode[ch] == 2 && alt_phase);
            end
        end
        sd_clk_prev = sd_clk;
    end

    ////////////////////
    // Stream monitor
    ////////////////////

    always @(posedge clock) begin
        int ch;
        int exp_v;
        if (rst_n && sample_valid && sample_ready) begin
            ch    = int'(sample.chan);
            exp_v = raw_val[ch] - offset_v[ch];
            if (frames_seen >= settle_until) begin
                assert (sample.value == 16'(exp_v)) else begin
                    tb_errors++;
                    $display("ERR %0t: chan %0d value %0d, expected %0d",
                             $time, ch, sample.value, exp_v);
                end
                assert (sample.fault_high == (exp_v > thr_hi[ch])
                        && sample.fault_low == (exp_v < thr_lo[ch])) else begin
                    tb_errors++;
                    $display("ERR %0t: chan %0d fault flags %0b%0b wrong",
                             $time, ch, sample.fault_high, sample.fault_low);
                end
            end
            if (ch == N_CH - 1) begin
                if (frames_seen >= settle_until) begin
                    checked_frames++;
                end
                frames_seen++;
            end
        end
    end

    // Watchdog sized from the frame budget of all tests
    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
        $display("Test failures found");
        $finish;
    end

    ////////////////////
    // Test sequence
    ////////////////////

    initial begin
        logic [11:0] addr;
        int          rand_val;
        apb_req      = '0;
        sample_ready = 1'b1;
        for (int ch = 0; ch < N_CH; ch++) begin
            raw_val[ch]  = 0;
            offset_v[ch] = 0;
            thr_hi[ch]   = 32767;
            thr_lo[ch]   = -32768;
            mode[ch]     = 0;
        end
        wait (rst_n);
        @(negedge clock);

        // Register readback with random data
        for (int ch = 0; ch < N_CH; ch++) begin
            for (int f = 0; f < 3; f++) begin
                addr      = 12'h010 + 12'(ch * 16 + f * 4);
                lcg_state = lcg_next(lcg_state);
                // Random 16-bit signed setting as a 32-bit word
                rand_val  = int'($signed(lcg_state[31:16]));
                apb_write(addr, 32'(rand_val));
                apb_read(addr, 32'(rand_val), 1'b0);
            end
        end
        apb_read(12'h008, 32'h0, 1'b1);
        apb_read(12'h0fc, 32'h0, 1'b1);

        // Constant densities
        set_chan_cfg(0, 100, 32767, -32768);
        set_chan_cfg(1, -50, 32767, -32768);
        set_pattern(0, 1, 4096);
        set_pattern(1, 0, 0);
        apb_write(REG_CTRL, 32'h1);
        wait_frames(3);

        // Half density with two offsets
        set_pattern(0, 2, 2048);
        set_pattern(1, 2, 2048);
        set_chan_cfg(0, 300, 32767, -32768);
        set_chan_cfg(1, -7, 32767, -32768);
        wait_frames(3);
        set_chan_cfg(0, 1000, 32767, -32768);
        set_chan_cfg(1, 0, 32767, -32768);
        wait_frames(3);

        // High fault on channel 0, then clear
        apb_write(REG_STATUS, 32'hffff_ffff);
        set_chan_cfg(0, 1000, 1000, -32768);
        wait_frames(2);
        apb_read(REG_STATUS, 32'h100, 1'b0);
        set_chan_cfg(0, 1000, 32767, -32768);
        wait_frames(2);
        apb_write(REG_STATUS, 32'h100);
        apb_read(REG_STATUS, 32'h0, 1'b0);

        // Low fault on channel 1, then clear
        set_chan_cfg(1, 0, 32767, 3000);
        wait_frames(2);
        apb_read(REG_STATUS, 32'h200, 1'b0);
        set_chan_cfg(1, 0, 32767, -32768);
        wait_frames(2);
        apb_write(REG_STATUS, 32'h200);
        apb_read(REG_STATUS, 32'h0, 1'b0);

        // Stall longer than two frames
        while (!sample_valid) begin
            @(negedge clock);
        end
        sample_ready = 1'b0;
        repeat (160) @(negedge clock);
        sample_ready = 1'b1;
        wait_frames(3);
        apb_read(REG_STATUS, 32'h1, 1'b0);
        apb_write(REG_STATUS, 32'h1);
        apb_read(REG_STATUS, 32'h0, 1'b0);

        // Disabled, let the last frame drain first
        apb_write(REG_CTRL, 32'h0);
        repeat (10) @(negedge clock);
        repeat (200) begin
            @(negedge clock);
            assert (!sd_clk && !sample_valid) else begin
                tb_errors++;
                $display("ERR %0t: activity while disabled, sd_clk %0b valid %0b",
                         $time, sd_clk, sample_valid);
            end
        end

        $display("Errors: testbench %0d, assertions %0d", tb_errors, i_dut.i_props.fail_count);
        if (tb_errors == 0 && i_dut.i_props.fail_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== sd_adc.f ====
design/sd_pkg.sv
design/sd_clock_gen.sv
design/sd_cic_channel.sv
design/sd_regs_apb.sv
design/sd_output_sequencer.sv
design/sd_processor.sv
testbench/tb_clock.sv
testbench/sd_props.sv
testbench/tb_sd_processor.sv

// ==== Makefile ====
TOP = tb_sd_processor

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f sd_adc.f \
		--top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee sim.log
	grep -q "All tests passed!" sim.log

lint:
	verilator --lint-only -Wall --timing --assert -f sd_adc.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
